// ==== Bender.yml ====
package:
  name: rp_analog

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/rp_adc_pkg.sv
      - rtl/rp_bus_pkg.sv
      - rtl/rp_adc_frontend.sv
      - rtl/rp_sys_bus_decoder.sv
      - rtl/rp_hk_regs.sv
      - rtl/rp_ams_regs.sv
      - rtl/rp_pdm_modulator.sv
      - rtl/rp_analog_top.sv
      - target: test
        files:
          - verification/rp_analog_assertions.sv
          - verification/rp_analog_tb.sv

// ==== compile.f ====
+incdir+include
rtl/rp_adc_pkg.sv
rtl/rp_bus_pkg.sv
rtl/rp_adc_frontend.sv
rtl/rp_sys_bus_decoder.sv
rtl/rp_hk_regs.sv
rtl/rp_ams_regs.sv
rtl/rp_pdm_modulator.sv
rtl/rp_analog_top.sv
verification/rp_analog_assertions.sv
verification/rp_analog_tb.sv

// ==== include/rp_analog_config.svh ====
/* board constants for the ADC clock domain of the four-channel top level
   widths are fixed by the board, nothing here is meant to be overridden
   register offsets are byte offsets inside a 1 MiB region */
`ifndef RP_ANALOG_CONFIG_SVH
`define RP_ANALOG_CONFIG_SVH

// channels and sample widths
`define RP_ADC_CH      4             // ADC and PDM channel count
`define RP_ADC_DW      14            // raw ADC word
`define RP_PDM_DW      8             // PDM level
`define RP_PDM_RANGE   255           // PDM modulus
`define RP_EXP_W       11            // expansion bank, positive side only
`define RP_LED_W       8

// system bus
`define RP_SYS_AW      32
`define RP_SYS_DW      32
`define RP_REGION_SW   20            // offset bits inside one region
`define RP_REGION_N    8
`define RP_REGION_HK   0
`define RP_REGION_AMS  4

// housekeeping map
`define RP_HK_ID       32'h0000_0000 // read only
`define RP_HK_EXP_DIR  32'h0000_0004 // 1 = pin driven
`define RP_HK_EXP_OUT  32'h0000_0008
`define RP_HK_EXP_IN   32'h0000_000C // synchronized pin state, read only
`define RP_HK_LED      32'h0000_0010
`define RP_HK_ID_VALUE 32'h5250_0004

// AMS map, one word per channel from here
`define RP_AMS_PDM0    32'h0000_0020

`endif

// ==== rtl/rp_adc_frontend.sv ====
/* converts unsigned negative-slope ADC words to two's complement
   fixed latency of two cycles, one new word per channel per cycle */
`timescale 1ns/1ps
`include "rp_analog_config.svh"

module rp_adc_frontend (
  input  logic                                     adc_clk_01,
  input  logic                                     rst_i,
  input  rp_adc_pkg::adc_raw_t [`RP_ADC_CH-1:0]    adc_raw_i,  // as captured
  output rp_adc_pkg::adc_smp_t [`RP_ADC_CH-1:0]    adc_smp_o   // signed samples
);

  import rp_adc_pkg::*;

  adc_smp_t [`RP_ADC_CH-1:0] conv_q;  // first stage

  //////////////////////////////////////////////////////////////////////
  // stage 1: flip the slope
  //////////////////////////////////////////////////////////////////////

  // msb kept, the rest inverted, which maps
  // full negative slope to signed
  always_ff @(posedge adc_clk_01) begin
    if (rst_i) begin
      conv_q <= '0;
    end else begin
      for (int ch = 0; ch < `RP_ADC_CH; ch++) begin
        conv_q[ch] <= adc_smp_t'({adc_raw_i[ch][`RP_ADC_DW-1],
                                 ~adc_raw_i[ch][`RP_ADC_DW-2:0]});
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stage 2: retime
  //////////////////////////////////////////////////////////////////////

  // extra register for routing margin to the consumers
  always_ff @(posedge adc_clk_01) begin
    if (rst_i) begin
      adc_smp_o <= '0;
    end else begin
      adc_smp_o <= conv_q;  // all channels move together
    end
  end

endmodule : rp_adc_frontend

// ==== rtl/rp_adc_pkg.sv ====
/* sample and level types of the analog path
   raw words are unsigned negative slope as they come off the converter */
`include "rp_analog_config.svh"

package rp_adc_pkg;

  ////////////////////////////////////////////////////////////////////
  // ADC samples
  ////////////////////////////////////////////////////////////////////

  // straight from the pins, no sign
  typedef logic [`RP_ADC_DW-1:0] adc_raw_t;

  // two's complement after conversion
  typedef logic signed [`RP_ADC_DW-1:0] adc_smp_t;

  ////////////////////////////////////////////////////////////////////
  // PDM outputs
  ////////////////////////////////////////////////////////////////////

  // duty level, full scale is RP_PDM_RANGE
  typedef logic [`RP_PDM_DW-1:0] pdm_lvl_t;

endpackage : rp_adc_pkg

// ==== rtl/rp_ams_regs.sv ====
/* PDM level registers, one word per channel from RP_AMS_PDM0
   only the low RP_PDM_DW bits of a write are kept, reads zero-extend */
`timescale 1ns/1ps
`include "rp_analog_config.svh"

module rp_ams_regs (
  input  logic                                   adc_clk_01,
  input  logic                                   rst_i,
  input  rp_bus_pkg::sys_req_t                   bus_req_i,
  output rp_bus_pkg::sys_rsp_t                   bus_rsp_o,
  output rp_adc_pkg::pdm_lvl_t [`RP_ADC_CH-1:0]  pdm_lvl_o  // to modulator
);

  import rp_adc_pkg::*;
  import rp_bus_pkg::*;

  logic [`RP_ADC_CH-1:0] ch_sel;    // one hot on a hit
  logic                  addr_hit;
  sys_data_t             rd_data;
  sys_data_t             rdata_q;
  logic                  ack_q;
  logic                  err_q;

  // channel decode, 4 byte stride
  always_comb begin
    ch_sel   = '0;
    addr_hit = 1'b0;
    rd_data  = '0;
    for (int ch = 0; ch < `RP_ADC_CH; ch++) begin
      if (bus_req_i.addr == `RP_AMS_PDM0 + sys_addr_t'(4 * ch)) begin
        ch_sel[ch] = 1'b1;
        addr_hit   = 1'b1;
        rd_data    = sys_data_t'(pdm_lvl_o[ch]);
      end
    end
  end

  always_ff @(posedge adc_clk_01) begin
    if (rst_i) begin
      pdm_lvl_o <= '0;  // outputs idle low
      ack_q     <= 1'b0;
      err_q     <= 1'b0;
    end else begin
      ack_q <= bus_req_i.wen | bus_req_i.ren;
      err_q <= (bus_req_i.wen | bus_req_i.ren) & ~addr_hit;
      for (int ch = 0; ch < `RP_ADC_CH; ch++) begin
        if (bus_req_i.wen && ch_sel[ch]) pdm_lvl_o[ch] <= pdm_lvl_t'(bus_req_i.wdata);
      end
    end
  end

  always_ff @(posedge adc_clk_01) begin
    if (bus_req_i.ren) rdata_q <= rd_data;  // zero on a miss
  end

  assign bus_rsp_o = '{rdata: rdata_q, ack: ack_q, err: err_q};

endmodule : rp_ams_regs

// ==== rtl/rp_analog_top.sv ====
/* ADC clock domain of the four-channel board: ADC conversion, bus
   decode, housekeeping, PDM levels and modulator
   single clock adc_clk_01, rst_i synchronous active high */
`timescale 1ns/1ps
`include "rp_analog_config.svh"

module rp_analog_top (
  input  logic                                   adc_clk_01,
  input  logic                                   rst_i,
  // ADC
  input  rp_adc_pkg::adc_raw_t [`RP_ADC_CH-1:0]  adc_raw_i,
  output rp_adc_pkg::adc_smp_t [`RP_ADC_CH-1:0]  adc_smp_o,  // 2 cycles after raw
  // system bus
  input  rp_bus_pkg::sys_req_t                   sys_req_i,
  output rp_bus_pkg::sys_rsp_t                   sys_rsp_o,
  // expansion connector and LEDs
  input  logic [`RP_EXP_W-1:0]                   exp_i,
  output logic [`RP_EXP_W-1:0]                   exp_o,
  output logic [`RP_EXP_W-1:0]                   exp_oe_o,
  output logic [`RP_LED_W-1:0]                   led_o,
  // PDM outputs
  output logic [`RP_ADC_CH-1:0]                  dac_pwm_o
);

  import rp_adc_pkg::*;
  import rp_bus_pkg::*;

  sys_req_t                  hk_req;
  sys_rsp_t                  hk_rsp;
  sys_req_t                  ams_req;
  sys_rsp_t                  ams_rsp;
  pdm_lvl_t [`RP_ADC_CH-1:0] pdm_lvl;  // AMS to modulator

  //////////////////////////////////////////////////////////////////////
  // ADC path
  //////////////////////////////////////////////////////////////////////

  rp_adc_frontend i_adc (
    .adc_clk_01 (adc_clk_01),
    .rst_i      (rst_i     ),
    .adc_raw_i  (adc_raw_i ),
    .adc_smp_o  (adc_smp_o )
  );

  //////////////////////////////////////////////////////////////////////
  // system bus and register blocks
  //////////////////////////////////////////////////////////////////////

  rp_sys_bus_decoder i_bus (
    .adc_clk_01 (adc_clk_01),
    .rst_i      (rst_i     ),
    .sys_req_i  (sys_req_i ),
    .sys_rsp_o  (sys_rsp_o ),
    .hk_req_o   (hk_req    ),  // region 0
    .hk_rsp_i   (hk_rsp    ),
    .ams_req_o  (ams_req   ),  // region 4
    .ams_rsp_i  (ams_rsp   )
  );

  rp_hk_regs i_hk (
    .adc_clk_01 (adc_clk_01),
    .rst_i      (rst_i     ),
    .bus_req_i  (hk_req    ),
    .bus_rsp_o  (hk_rsp    ),
    .exp_i      (exp_i     ),
    .exp_o      (exp_o     ),
    .exp_oe_o   (exp_oe_o  ),
    .led_o      (led_o     )
  );

  rp_ams_regs i_ams (
    .adc_clk_01 (adc_clk_01),
    .rst_i      (rst_i     ),
    .bus_req_i  (ams_req   ),
    .bus_rsp_o  (ams_rsp   ),
    .pdm_lvl_o  (pdm_lvl   )
  );

  //////////////////////////////////////////////////////////////////////
  // PDM outputs
  //////////////////////////////////////////////////////////////////////

  rp_pdm_modulator i_pdm (
    .adc_clk_01 (adc_clk_01),
    .rst_i      (rst_i     ),
    .pdm_lvl_i  (pdm_lvl   ),
    .dac_pwm_o  (dac_pwm_o )
  );

endmodule : rp_analog_top

// ==== rtl/rp_bus_pkg.sv ====
/* system bus types, single strobe per request and single cycle response
   no byte enables, no back-pressure, master waits for ack
   the region index selects one of RP_REGION_N address windows */
`include "rp_analog_config.svh"

package rp_bus_pkg;

  typedef logic [`RP_SYS_AW-1:0] sys_addr_t;   // byte address
  typedef logic [`RP_SYS_DW-1:0] sys_data_t;

  // which 1 MiB window, taken above the offset bits
  typedef logic [$clog2(`RP_REGION_N)-1:0] region_t;

  ////////////////////////////////////////////////////////////////////
  // master to slave
  ////////////////////////////////////////////////////////////////////

  typedef struct packed {
    sys_addr_t addr;   // full address at the top, offset only at a slave
    sys_data_t wdata;
    logic      wen;    // one cycle strobe
    logic      ren;    // one cycle strobe
  } sys_req_t;

  ////////////////////////////////////////////////////////////////////
  // slave to master
  ////////////////////////////////////////////////////////////////////

  typedef struct packed {
    sys_data_t rdata;  // valid with a read ack
    logic      ack;    // cycle after the strobe
    logic      err;    // only with ack
  } sys_rsp_t;

endpackage : rp_bus_pkg

// ==== rtl/rp_hk_regs.sv ====
/* housekeeping registers: ID, LED and the positive expansion bank
   exp_i is asynchronous, readback goes through two flops
   ID and exp input are read only, writes to them are acked and dropped */
`timescale 1ns/1ps
`include "rp_analog_config.svh"

module rp_hk_regs (
  input  logic                  adc_clk_01,
  input  logic                  rst_i,
  input  rp_bus_pkg::sys_req_t  bus_req_i,  // offset addressed
  output rp_bus_pkg::sys_rsp_t  bus_rsp_o,
  input  logic [`RP_EXP_W-1:0]  exp_i,      // pin state
  output logic [`RP_EXP_W-1:0]  exp_o,
  output logic [`RP_EXP_W-1:0]  exp_oe_o,   // 1 = drive the pin
  output logic [`RP_LED_W-1:0]  led_o
);

  import rp_bus_pkg::*;

  logic [`RP_EXP_W-1:0] exp_meta_q;
  logic [`RP_EXP_W-1:0] exp_sync_q;
  sys_data_t            rd_data;
  sys_data_t            rdata_q;
  logic                 addr_hit;   // offset is in the map
  logic                 ack_q;
  logic                 err_q;

  // read mux, zero for anything unknown
  always_comb begin
    rd_data  = '0;
    addr_hit = 1'b1;
    case (bus_req_i.addr)
      `RP_HK_ID:      rd_data = `RP_HK_ID_VALUE;
      `RP_HK_EXP_DIR: rd_data = sys_data_t'(exp_oe_o);
      `RP_HK_EXP_OUT: rd_data = sys_data_t'(exp_o);
      `RP_HK_EXP_IN:  rd_data = sys_data_t'(exp_sync_q);
      `RP_HK_LED:     rd_data = sys_data_t'(led_o);
      default:        addr_hit = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // registers and response
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk_01) begin
    if (rst_i) begin
      exp_meta_q <= '0;
      exp_sync_q <= '0;
      exp_oe_o   <= '0;   // all pins inputs
      exp_o      <= '0;
      led_o      <= '0;
      ack_q      <= 1'b0;
      err_q      <= 1'b0;
    end else begin
      exp_meta_q <= exp_i;
      exp_sync_q <= exp_meta_q;  // two cycles behind the pin
      ack_q      <= bus_req_i.wen | bus_req_i.ren;
      err_q      <= (bus_req_i.wen | bus_req_i.ren) & ~addr_hit;
      if (bus_req_i.wen) begin
        case (bus_req_i.addr)
          `RP_HK_EXP_DIR: exp_oe_o <= bus_req_i.wdata[`RP_EXP_W-1:0];
          `RP_HK_EXP_OUT: exp_o    <= bus_req_i.wdata[`RP_EXP_W-1:0];
          `RP_HK_LED:     led_o    <= bus_req_i.wdata[`RP_LED_W-1:0];
          default: ;                 // read only or unmapped
        endcase
      end
    end
  end

  // read data captured on the strobe
  always_ff @(posedge adc_clk_01) begin
    if (bus_req_i.ren) rdata_q <= rd_data;
  end

  assign bus_rsp_o = '{rdata: rdata_q, ack: ack_q, err: err_q};

endmodule : rp_hk_regs

// ==== rtl/rp_pdm_modulator.sv ====
/* first-order PDM, modulus RP_PDM_RANGE, always enabled
   a constant level L gives exactly L ones in any RP_PDM_RANGE cycles */
`timescale 1ns/1ps
`include "rp_analog_config.svh"

module rp_pdm_modulator (
  input  logic                                   adc_clk_01,
  input  logic                                   rst_i,
  input  rp_adc_pkg::pdm_lvl_t [`RP_ADC_CH-1:0]  pdm_lvl_i,  // may change any cycle
  output logic [`RP_ADC_CH-1:0]                  dac_pwm_o   // to RC filters
);

  // one extra bit, acc + level stays below 2 * range
  localparam logic [`RP_PDM_DW:0] pdm_range = `RP_PDM_RANGE;

  logic [`RP_ADC_CH-1:0][`RP_PDM_DW:0] acc_q;
  logic [`RP_ADC_CH-1:0][`RP_PDM_DW:0] acc_sum;

  always_comb begin
    for (int ch = 0; ch < `RP_ADC_CH; ch++) begin
      acc_sum[ch] = acc_q[ch] + {1'b0, pdm_lvl_i[ch]};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // accumulate and wrap
  //////////////////////////////////////////////////////////////////////

  // acc stays in 0 .. range-1, a wrap emits one pulse
  always_ff @(posedge adc_clk_01) begin
    if (rst_i) begin
      acc_q     <= '0;
      dac_pwm_o <= '0;
    end else begin
      for (int ch = 0; ch < `RP_ADC_CH; ch++) begin
        if (acc_sum[ch] >= pdm_range) begin
          acc_q[ch]     <= acc_sum[ch] - pdm_range;
          dac_pwm_o[ch] <= 1'b1;
        end else begin
          acc_q[ch]     <= acc_sum[ch];
          dac_pwm_o[ch] <= 1'b0;
        end
      end
    end
  end

endmodule : rp_pdm_modulator

// ==== rtl/rp_sys_bus_decoder.sv ====
/* splits the bus into RP_REGION_N windows of 2^RP_REGION_SW bytes
   only housekeeping and AMS are mapped, the rest answer ack with err
   one request at a time, the response is muxed by the registered region */
`timescale 1ns/1ps
`include "rp_analog_config.svh"

module rp_sys_bus_decoder (
  input  logic                  adc_clk_01,
  input  logic                  rst_i,
  input  rp_bus_pkg::sys_req_t  sys_req_i,  // from master
  output rp_bus_pkg::sys_rsp_t  sys_rsp_o,
  output rp_bus_pkg::sys_req_t  hk_req_o,   // region 0
  input  rp_bus_pkg::sys_rsp_t  hk_rsp_i,
  output rp_bus_pkg::sys_req_t  ams_req_o,  // region 4
  input  rp_bus_pkg::sys_rsp_t  ams_rsp_i
);

  import rp_bus_pkg::*;

  region_t                  region;
  region_t                  region_q;    // region of the pending request
  logic [`RP_REGION_SW-1:0] offset;
  logic                     strobe;
  logic                     hk_sel;
  logic                     ams_sel;
  logic                     stub_ack_q;  // own answer for unmapped windows

  assign region  = sys_req_i.addr[`RP_REGION_SW +: $bits(region_t)];
  assign offset  = sys_req_i.addr[`RP_REGION_SW-1:0];
  assign strobe  = sys_req_i.wen | sys_req_i.ren;
  assign hk_sel  = (region == region_t'(`RP_REGION_HK));
  assign ams_sel = (region == region_t'(`RP_REGION_AMS));

  //////////////////////////////////////////////////////////////////////
  // request fan-out
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    hk_req_o      = sys_req_i;
    hk_req_o.addr = sys_addr_t'(offset);  // slaves see offset only
    hk_req_o.wen  = sys_req_i.wen & hk_sel;
    hk_req_o.ren  = sys_req_i.ren & hk_sel;

    ams_req_o      = sys_req_i;
    ams_req_o.addr = sys_addr_t'(offset);
    ams_req_o.wen  = sys_req_i.wen & ams_sel;
    ams_req_o.ren  = sys_req_i.ren & ams_sel;
  end

  always_ff @(posedge adc_clk_01) begin
    if (rst_i) begin
      region_q   <= '0;
      stub_ack_q <= 1'b0;
    end else begin
      stub_ack_q <= strobe & ~hk_sel & ~ams_sel;
      if (strobe) region_q <= region;  // held until the next request
    end
  end

  //////////////////////////////////////////////////////////////////////
  // response mux
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (region_q)
      region_t'(`RP_REGION_HK):  sys_rsp_o = hk_rsp_i;
      region_t'(`RP_REGION_AMS): sys_rsp_o = ams_rsp_i;
      default: begin
        sys_rsp_o.rdata = '0;          // unmapped reads as zero
        sys_rsp_o.ack   = stub_ack_q;
        sys_rsp_o.err   = stub_ack_q;
      end
    endcase
  end

endmodule : rp_sys_bus_decoder

// ==== verification/rp_analog_assertions.sv ====
/* bus and reset checks, bound into rp_analog_top
   assumes one outstanding request and a response one cycle after the strobe
   assert_fails is read by the testbench at the end of the run */
`timescale 1ns/1ps
`include "rp_analog_config.svh"

module rp_analog_assertions (
  input logic                  adc_clk_01,
  input logic                  rst_i,
  input rp_bus_pkg::sys_req_t  req_i,       // master request at the top
  input rp_bus_pkg::sys_rsp_t  rsp_i,
  input logic [`RP_ADC_CH-1:0] pwm_i,
  input logic [`RP_LED_W-1:0]  led_i,
  input logic [`RP_EXP_W-1:0]  exp_out_i,
  input logic [`RP_EXP_W-1:0]  exp_oe_i
);

  int assert_fails = 0;
  logic strobe;

  assign strobe = req_i.wen | req_i.ren;

  // response exactly one cycle after the strobe
  assert property (@(posedge adc_clk_01) disable iff (rst_i) strobe |=> rsp_i.ack)
    else begin
      assert_fails++;
      $error("ack missing one cycle after a strobe");
    end

  // no spurious ack
  assert property (@(posedge adc_clk_01) disable iff (rst_i) rsp_i.ack |-> $past(strobe))
    else begin
      assert_fails++;
      $error("ack without a strobe in the cycle before");
    end

  assert property (@(posedge adc_clk_01) disable iff (rst_i) rsp_i.err |-> rsp_i.ack)
    else begin
      assert_fails++;
      $error("err raised without ack");
    end

  // first cycle out of reset, everything quiet
  assert property (@(posedge adc_clk_01) $fell(rst_i) |->
                   (pwm_i == '0) && (led_i == '0) && (exp_out_i == '0) &&
                   (exp_oe_i == '0) && !rsp_i.ack && !rsp_i.err)
    else begin
      assert_fails++;
      $error("control outputs not zero after reset");
    end

endmodule : rp_analog_assertions

bind rp_analog_top rp_analog_assertions rp_analog_assertions_i (
  .adc_clk_01 (adc_clk_01),
  .rst_i      (rst_i     ),
  .req_i      (sys_req_i ),
  .rsp_i      (sys_rsp_o ),
  .pwm_i      (dac_pwm_o ),
  .led_i      (led_o     ),
  .exp_out_i  (exp_o     ),
  .exp_oe_i   (exp_oe_o  )
);

// ==== verification/rp_analog_tb.sv ====
/* testbench for rp_analog_top, inputs change on the falling edge
   bus accesses are strictly one at a time, each waits for ack
   ADC outputs are compared by a separate process against a 2-deep history */
`timescale 1ns/1ps
`include "rp_analog_config.svh"

module rp_analog_tb;

  import rp_adc_pkg::*;
  import rp_bus_pkg::*;

  localparam int        bus_timeout = 16;     // cycles to wait for ack
  localparam int        run_limit   = 20000;  // whole run
  localparam sys_addr_t hk_base     = sys_addr_t'(`RP_REGION_HK) << `RP_REGION_SW;
  localparam sys_addr_t ams_base    = sys_addr_t'(`RP_REGION_AMS) << `RP_REGION_SW;

  logic                      adc_clk_01;
  logic                      rst_i;
  adc_raw_t [`RP_ADC_CH-1:0] adc_raw;
  adc_smp_t [`RP_ADC_CH-1:0] adc_smp;
  sys_req_t                  sys_req;
  sys_rsp_t                  sys_rsp;
  logic [`RP_EXP_W-1:0]      exp_in;
  logic [`RP_EXP_W-1:0]      exp_out;
  logic [`RP_EXP_W-1:0]      exp_oe;
  logic [`RP_LED_W-1:0]      led;
  logic [`RP_ADC_CH-1:0]     dac_pwm;

  integer seed;
  int     n_tests = 0;
  int     n_checks = 0;
  int     n_errors = 0;
  // ADC compare process state
  logic                      adc_chk_en = 1'b0;
  int                        adc_fill = 0;
  int                        adc_checks = 0;
  adc_raw_t [`RP_ADC_CH-1:0] raw_d1;
  adc_raw_t [`RP_ADC_CH-1:0] raw_d2;

  rp_analog_top rp_analog_top_i (
    .adc_clk_01 (adc_clk_01),
    .rst_i      (rst_i     ),
    .adc_raw_i  (adc_raw   ),
    .adc_smp_o  (adc_smp   ),
    .sys_req_i  (sys_req   ),
    .sys_rsp_o  (sys_rsp   ),
    .exp_i      (exp_in    ),
    .exp_o      (exp_out   ),
    .exp_oe_o   (exp_oe    ),
    .led_o      (led       ),
    .dac_pwm_o  (dac_pwm   )
  );

  initial begin
    adc_clk_01 = 1'b0;
    forever #20 adc_clk_01 = ~adc_clk_01;  // 25 MHz
  end

  //////////////////////////////////////////////////////////////////////
  // reference model and helpers
  //////////////////////////////////////////////////////////////////////

  // negative slope: keep the sign position, mirror the magnitude bits
  function automatic adc_smp_t ref_adc_conv(input adc_raw_t raw);
    return adc_smp_t'(raw ^ {1'b0, {(`RP_ADC_DW-1){1'b1}}});
  endfunction

  task automatic expect_eq(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  // one strobe, then poll ack on falling edges; entered on a falling edge
  task automatic bus_access(input logic wr, input sys_addr_t addr, input sys_data_t wdata,
                            output sys_data_t rdata, output logic err);
    int wait_cnt;
    sys_req.addr  = addr;
    sys_req.wdata = wdata;
    sys_req.wen   = wr;
    sys_req.ren   = ~wr;
    @(negedge adc_clk_01);
    sys_req.wen = 1'b0;
    sys_req.ren = 1'b0;
    wait_cnt    = 0;
    while (!sys_rsp.ack && wait_cnt < bus_timeout) begin
      @(negedge adc_clk_01);
      wait_cnt++;
    end
    if (!sys_rsp.ack) begin
      n_errors++;
      $display("bus timeout: no ack for address 0x%h", addr);
      rdata = '0;
      err   = 1'b1;
    end else begin
      rdata = sys_rsp.rdata;
      err   = sys_rsp.err;
    end
  endtask

  task automatic write_reg(input sys_addr_t addr, input sys_data_t data);
    sys_data_t rd;
    logic      err;
    bus_access(1'b1, addr, data, rd, err);
    n_checks++;
    if (err) begin
      n_errors++;
      $display("write to 0x%h got an error response", addr);
    end
  endtask

  task automatic read_expect(input sys_addr_t addr, input sys_data_t exp, input string name);
    sys_data_t rd;
    logic      err;
    bus_access(1'b0, addr, '0, rd, err);
    n_checks++;
    if (err) begin
      n_errors++;
      $display("read of %s at 0x%h got an error response", name, addr);
    end else if (rd !== exp) begin
      n_errors++;
      $display("Mismatch %s: got 0x%h expected 0x%h", name, rd, exp);
    end
  endtask

  // request that must come back as ack with err, reads return zero
  task automatic expect_bus_err(input logic wr, input sys_addr_t addr);
    sys_data_t rd;
    logic      err;
    bus_access(wr, addr, 32'hDEAD_BEEF, rd, err);
    n_checks++;
    if (!err) begin
      n_errors++;
      $display("no error response for %s at 0x%h", wr ? "write" : "read", addr);
    end
    if (!wr && rd !== '0) begin
      n_errors++;
      $display("Mismatch sys_rsp_o.rdata: got 0x%h expected 0x%h", rd, 32'h0);
    end
  endtask

  task automatic finish_test(input string name, input int errs_at_start);
    n_tests++;
    if (n_errors == errs_at_start) $display("test %-8s ok", name);
    else $display("test %-8s fail, %0d errors", name, n_errors - errs_at_start);
  endtask

  //////////////////////////////////////////////////////////////////////
  // ADC compare process
  //////////////////////////////////////////////////////////////////////

  // values read here are the ones before this edge updates them
  always @(posedge adc_clk_01) begin
    if (rst_i || !adc_chk_en) begin
      adc_fill = 0;
    end else begin
      if (adc_fill == 2) begin
        adc_checks++;
        for (int ch = 0; ch < `RP_ADC_CH; ch++) begin
          if (adc_smp[ch] !== ref_adc_conv(raw_d2[ch])) begin
            n_errors++;
            $display("Mismatch adc_smp_o[%0d]: got 0x%h expected 0x%h",
                     ch, adc_smp[ch], ref_adc_conv(raw_d2[ch]));
          end
        end
      end else begin
        adc_fill++;
      end
      raw_d2 = raw_d1;   // two edges old
      raw_d1 = adc_raw;
    end
  end

  // hard stop in case a loop never ends
  initial begin
    repeat (run_limit) @(posedge adc_clk_01);
    $display("timeout: run did not finish within %0d cycles", run_limit);
    $display("Result: FAILED");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    pdm_lvl_t  fixed_lvl [`RP_ADC_CH];
    pdm_lvl_t  lvl [`RP_ADC_CH];
    int        ones [`RP_ADC_CH];
    int        errs0;
    sys_data_t led_w;
    sys_data_t dir_w;
    sys_data_t out_w;
    sys_addr_t addr;

    fixed_lvl = '{8'd0, 8'd1, 8'd128, 8'd255};
    seed      = 3;
    rst_i     = 1'b1;
    adc_raw   = '0;
    sys_req   = '0;
    exp_in    = '0;
    repeat (3) @(posedge adc_clk_01);
    @(negedge adc_clk_01);
    rst_i = 1'b0;

    // reset state, first cycle out of reset
    errs0 = n_errors;
    expect_eq("dac_pwm_o", 32'(dac_pwm), 32'h0);
    expect_eq("led_o", 32'(led), 32'h0);
    expect_eq("exp_o", 32'(exp_out), 32'h0);
    expect_eq("exp_oe_o", 32'(exp_oe), 32'h0);
    n_checks++;
    if (adc_smp !== '0) begin
      n_errors++;
      $display("Mismatch adc_smp_o: got 0x%h expected 0x%h", adc_smp, '0);
    end
    repeat (4) begin
      expect_eq("sys_rsp_o.ack", 32'(sys_rsp.ack), 32'h0);  // nothing requested yet
      @(negedge adc_clk_01);
    end
    finish_test("reset", errs0);

    // ADC conversion, both extremes first
    errs0      = n_errors;
    adc_checks = 0;
    adc_chk_en = 1'b1;
    for (int cyc = 0; cyc < 200; cyc++) begin
      for (int ch = 0; ch < `RP_ADC_CH; ch++) begin
        if (cyc == 0) adc_raw[ch] = '0;
        else if (cyc == 1) adc_raw[ch] = '1;
        else adc_raw[ch] = adc_raw_t'($random(seed));
      end
      @(negedge adc_clk_01);
    end
    repeat (3) @(negedge adc_clk_01);
    adc_chk_en = 1'b0;
    n_checks++;
    if (adc_checks < 190) begin
      n_errors++;
      $display("ADC compare process ran only %0d checks", adc_checks);
    end
    finish_test("adc", errs0);

    // housekeeping registers
    errs0 = n_errors;
    read_expect(hk_base + `RP_HK_ID, `RP_HK_ID_VALUE, "hk id");
    write_reg(hk_base + `RP_HK_ID, 32'hFFFF_FFFF);           // ignored
    read_expect(hk_base + `RP_HK_ID, `RP_HK_ID_VALUE, "hk id after write");
    led_w = $random(seed);
    dir_w = $random(seed);
    out_w = $random(seed);
    write_reg(hk_base + `RP_HK_LED, led_w);
    write_reg(hk_base + `RP_HK_EXP_DIR, dir_w);
    write_reg(hk_base + `RP_HK_EXP_OUT, out_w);
    // only the register width survives
    read_expect(hk_base + `RP_HK_LED, 32'(led_w[`RP_LED_W-1:0]), "hk led");
    read_expect(hk_base + `RP_HK_EXP_DIR, 32'(dir_w[`RP_EXP_W-1:0]), "hk exp dir");
    read_expect(hk_base + `RP_HK_EXP_OUT, 32'(out_w[`RP_EXP_W-1:0]), "hk exp out");
    expect_eq("led_o", 32'(led), 32'(led_w[`RP_LED_W-1:0]));
    expect_eq("exp_oe_o", 32'(exp_oe), 32'(dir_w[`RP_EXP_W-1:0]));
    expect_eq("exp_o", 32'(exp_out), 32'(out_w[`RP_EXP_W-1:0]));
    finish_test("hk", errs0);

    // expansion input through the synchronizer
    errs0 = n_errors;
    repeat (3) begin
      exp_in = `RP_EXP_W'($random(seed));
      repeat (3) @(negedge adc_clk_01);
      read_expect(hk_base + `RP_HK_EXP_IN, 32'(exp_in), "hk exp in");
    end
    finish_test("exp_in", errs0);

    // PDM levels, fixed corners then two random rounds
    errs0 = n_errors;
    for (int rnd = 0; rnd < 3; rnd++) begin
      for (int ch = 0; ch < `RP_ADC_CH; ch++) begin
        lvl[ch] = (rnd == 0) ? fixed_lvl[ch] : pdm_lvl_t'($random(seed));
        write_reg(ams_base + `RP_AMS_PDM0 + 4 * ch, 32'(lvl[ch]));
      end
      for (int ch = 0; ch < `RP_ADC_CH; ch++) begin
        read_expect(ams_base + `RP_AMS_PDM0 + 4 * ch, 32'(lvl[ch]), "ams pdm level");
        ones[ch] = 0;
      end
      repeat (`RP_PDM_RANGE) begin
        @(negedge adc_clk_01);
        for (int ch = 0; ch < `RP_ADC_CH; ch++) ones[ch] += dac_pwm[ch];
      end
      for (int ch = 0; ch < `RP_ADC_CH; ch++) begin
        expect_eq($sformatf("dac_pwm_o[%0d] ones", ch), 32'(ones[ch]), 32'(lvl[ch]));
      end
    end
    finish_test("pdm", errs0);

    // unmapped regions and unknown offsets
    errs0 = n_errors;
    for (int r = 1; r < `RP_REGION_N; r++) begin
      if (r != `RP_REGION_AMS) begin
        addr = (sys_addr_t'(r) << `RP_REGION_SW) | (sys_addr_t'($random(seed)) & 32'h000F_FFFC);
        expect_bus_err(1'b0, addr);
        expect_bus_err(1'b1, addr);
      end
    end
    expect_bus_err(1'b0, hk_base + 32'h14);
    expect_bus_err(1'b1, hk_base + 32'h1000);
    expect_bus_err(1'b0, ams_base + `RP_AMS_PDM0 + 4 * `RP_ADC_CH);
    expect_bus_err(1'b1, ams_base + 32'h1C);
    expect_bus_err(1'b0, ams_base);
    finish_test("bus_err", errs0);

    repeat (2) @(negedge adc_clk_01);
    n_errors += rp_analog_top_i.rp_analog_assertions_i.assert_fails;
    $display("tests: %0d, checks: %0d, errors: %0d", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule : rp_analog_tb
